// ==== verilog.f ====
+incdir+src
src/id_pkg.sv
src/id_decoder.sv
src/id_operand_mux.sv
src/id_fsm.sv
src/id_stage.sv
verif/id_stage_tb.sv

// ==== Makefile ====
# Verilator build and run for the decode stage testbench

VERILATOR  = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing -Wall
TOP        = id_stage_tb
FILELIST   = verilog.f
OBJDIR     = obj_dir
PASS_MSG   = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Pass only if the pass line appears in the simulation output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== verif/id_stage_tb.sv ====
/*
 * Testbench for the RV32I decode and issue stage
 * Random register values and immediates, cycle checks against the ISA rules
 */

`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module id_stage_tb import id_pkg::*; ();

  // Base ISA opcodes
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_JALR   = 7'h67;

  // ALU op per funct3 with funct7 zero
  localparam alu_op_e BASE_OP [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                      ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
  // Branch funct3 and compare op
  localparam logic [2:0] BR_F3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
  localparam alu_op_e    BR_OP [6] = '{ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      instr_valid_i;
  instr_t    instr_i;
  word_t     pc_i;
  logic      instr_done_o;
  logic      illegal_insn_o;
  reg_addr_t rf_raddr_a_o;
  reg_addr_t rf_raddr_b_o;
  word_t     rf_rdata_a_i;
  word_t     rf_rdata_b_i;
  ex_req_t   ex_req_o;
  logic      branch_decision_i;
  logic      ex_valid_i;
  word_t     result_ex_i;
  logic      lsu_req_o;
  lsu_req_t  lsu_req_s_o;
  logic      lsu_resp_valid_i;
  logic      pc_set_o;
  logic      rf_we_o;
  reg_addr_t rf_waddr_o;
  word_t     rf_wdata_o;

  integer    seed;
  reg_addr_t rs1, rs2, rd;

  always #10 clk_i = ~clk_i;

  id_stage dut0 (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  task automatic fail_now(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp)
    else fail_now($sformatf("MISMATCH time=%0t %s got=0x%h expected=0x%h",
                            $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_word(name, word_t'(got), word_t'(exp));
  endtask

  // Sign-extend the low bits of v
  function automatic word_t sext(input word_t v, input int bits);
    word_t sh;
    sh = v << (`ID_XLEN - bits);
    return word_t'($signed(sh) >>> (`ID_XLEN - bits));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encoders, RV32I formats
  function automatic instr_t enc_r(input logic [6:0] f7, input reg_addr_t b, input reg_addr_t a,
                                   input logic [2:0] f3, input reg_addr_t d, input logic [6:0] opc);
    return {f7, b, a, f3, d, opc};
  endfunction

  function automatic instr_t enc_i(input logic [11:0] imm, input reg_addr_t a,
                                   input logic [2:0] f3, input reg_addr_t d, input logic [6:0] opc);
    return {imm, a, f3, d, opc};
  endfunction

  function automatic instr_t enc_s(input logic [11:0] imm, input reg_addr_t b,
                                   input reg_addr_t a, input logic [2:0] f3);
    return {imm[11:5], b, a, f3, imm[4:0], OPC_STORE};
  endfunction

  // Branch offset bits scattered, bit 0 implied
  function automatic instr_t enc_b(input logic [12:0] imm, input reg_addr_t b,
                                   input reg_addr_t a, input logic [2:0] f3);
    return {imm[12], imm[10:5], b, a, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic instr_t enc_j(input logic [20:0] imm, input reg_addr_t d);
    return {imm[20], imm[10:1], imm[11], imm[19:12], d, 7'h6f};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  task automatic pick_regs();
    rs1 = 5'($random(seed));
    rs2 = 5'($random(seed));
    rd  = 5'($random(seed));
  endtask

  // New instruction with fresh register file and EX values
  task automatic start(input instr_t ins, input logic taken);
    @(posedge clk_i);
    instr_valid_i     <= 1'b1;
    instr_i           <= ins;
    pc_i              <= word_t'($random(seed)) & ~word_t'(3);
    rf_rdata_a_i      <= $random(seed);
    rf_rdata_b_i      <= $random(seed);
    result_ex_i       <= $random(seed);
    branch_decision_i <= taken;
    ex_valid_i        <= 1'b1;
    lsu_resp_valid_i  <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic check_quiet();
    check_bit("instr_done_o", instr_done_o, 1'b0);
    check_bit("rf_we_o", rf_we_o, 1'b0);
    check_bit("lsu_req_o", lsu_req_o, 1'b0);
    check_bit("pc_set_o", pc_set_o, 1'b0);
    check_bit("illegal_insn_o", illegal_insn_o, 1'b0);
  endtask

  // Drop valid, nothing may fire while idle
  task automatic release_instr();
    @(posedge clk_i);
    instr_valid_i     <= 1'b0;
    lsu_resp_valid_i  <= 1'b0;
    ex_valid_i        <= 1'b1;
    branch_decision_i <= 1'b0;
    @(negedge clk_i);
    check_quiet();
  endtask

  task automatic check_ex(input alu_op_e op, input word_t a, input word_t b);
    check_word("ex_req_o.alu_op", word_t'(ex_req_o.alu_op), word_t'(op));
    check_word("ex_req_o.operand_a", ex_req_o.operand_a, a);
    check_word("ex_req_o.operand_b", ex_req_o.operand_b, b);
    check_bit("illegal_insn_o", illegal_insn_o, 1'b0);
  endtask

  // Done cycle, write port carries rd and the EX result
  task automatic check_complete(input logic we);
    check_bit("instr_done_o", instr_done_o, 1'b1);
    check_bit("rf_we_o", rf_we_o, we);
    check_bit("lsu_req_o", lsu_req_o, 1'b0);
    // Write address only matters with the write enable
    if (we) begin
      check_word("rf_waddr_o", word_t'(rf_waddr_o), word_t'(rd));
    end
    check_word("rf_wdata_o", rf_wdata_o, result_ex_i);
  endtask

  // Completion held off for delay cycles after cycle 1
  task automatic wait_done(input logic use_lsu, input int delay);
    int   n;
    logic seen;
    seen = 1'b0;
    for (n = 1; n <= 20 && !seen; n++) begin
      @(posedge clk_i);
      if (use_lsu) begin
        lsu_resp_valid_i <= (n > delay);
      end else begin
        ex_valid_i <= (n > delay);
      end
      @(negedge clk_i);
      check_bit("lsu_req_o", lsu_req_o, 1'b0);
      check_bit("pc_set_o", pc_set_o, 1'b0);
      check_bit("instr_done_o", instr_done_o, n > delay);
      if (n <= delay) begin
        check_bit("rf_we_o", rf_we_o, 1'b0);
      end
      seen = instr_done_o;
    end
    if (!seen) begin
      fail_now("timeout: instr_done_o never rose after the completion");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Instruction classes
  task automatic alu_rr(input logic [2:0] f3, input logic alt, input alu_op_e op);
    pick_regs();
    start(enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd, OPC_OP), 1'b0);
    check_word("rf_raddr_a_o", word_t'(rf_raddr_a_o), word_t'(rs1));
    check_word("rf_raddr_b_o", word_t'(rf_raddr_b_o), word_t'(rs2));
    check_ex(op, rf_rdata_a_i, rf_rdata_b_i);
    check_complete(1'b1);
    release_instr();
  endtask

  task automatic alu_ri(input logic [2:0] f3, input logic alt, input alu_op_e op);
    logic [11:0] imm;
    pick_regs();
    imm = 12'($random(seed));
    // Shifts carry funct7 in the upper immediate bits
    if (f3 == 3'b001 || f3 == 3'b101) begin
      imm[11:5] = {1'b0, alt, 5'b0};
    end
    start(enc_i(imm, rs1, f3, rd, OPC_OP_IMM), 1'b0);
    check_ex(op, rf_rdata_a_i, sext(word_t'(imm), 12));
    check_complete(1'b1);
    release_instr();
  endtask

  task automatic run_upper(input logic is_lui);
    logic [19:0] imm;
    pick_regs();
    imm = 20'($random(seed));
    start({imm, rd, is_lui ? OPC_LUI : OPC_AUIPC}, 1'b0);
    check_ex(ALU_ADD, is_lui ? '0 : pc_i, {imm, 12'b0});
    check_complete(1'b1);
    release_instr();
  endtask

  task automatic run_mem(input logic is_load, input logic [2:0] f3, input lsu_type_e typ,
                         input logic sign_ext);
    logic [11:0] imm;
    int          delay;
    pick_regs();
    imm   = 12'($random(seed));
    delay = {$random(seed)} % 4;
    if (is_load) begin
      start(enc_i(imm, rs1, f3, rd, OPC_LOAD), 1'b0);
    end else begin
      start(enc_s(imm, rs2, rs1, f3), 1'b0);
    end
    // Address rs1 plus offset, one request in cycle 1
    check_ex(ALU_ADD, rf_rdata_a_i, sext(word_t'(imm), 12));
    check_bit("lsu_req_o", lsu_req_o, 1'b1);
    check_bit("instr_done_o", instr_done_o, 1'b0);
    check_bit("lsu_req_s_o.we", lsu_req_s_o.we, ~is_load);
    check_word("lsu_req_s_o.data_type", word_t'(lsu_req_s_o.data_type), word_t'(typ));
    check_bit("lsu_req_s_o.sign_ext", lsu_req_s_o.sign_ext, sign_ext);
    check_word("lsu_req_s_o.wdata", lsu_req_s_o.wdata, rf_rdata_b_i);
    wait_done(1'b1, delay);
    check_complete(is_load);
    release_instr();
  endtask

  task automatic run_branch(input logic [2:0] f3, input alu_op_e op, input logic taken);
    logic [12:0] imm;
    pick_regs();
    imm = 13'($random(seed)) & 13'h1ffe;
    start(enc_b(imm, rs2, rs1, f3), taken);
    check_ex(op, rf_rdata_a_i, rf_rdata_b_i);
    check_bit("pc_set_o", pc_set_o, 1'b0);
    if (!taken) begin
      check_complete(1'b0);
    end else begin
      check_bit("instr_done_o", instr_done_o, 1'b0);
      @(posedge clk_i);
      @(negedge clk_i);
      // Target in cycle 2 with the redirect
      check_bit("pc_set_o", pc_set_o, 1'b1);
      check_ex(ALU_ADD, pc_i, sext(word_t'(imm), 13));
      check_complete(1'b0);
    end
    release_instr();
  endtask

  task automatic run_jump(input logic is_jalr, input int delay);
    logic [11:0] imm_i;
    logic [20:0] imm_j;
    pick_regs();
    imm_i = 12'($random(seed));
    imm_j = 21'($random(seed)) & 21'h1ffffe;
    if (is_jalr) begin
      start(enc_i(imm_i, rs1, 3'b000, rd, OPC_JALR), 1'b0);
    end else begin
      start(enc_j(imm_j, rd), 1'b0);
    end
    // Redirect in cycle 1, operands form the target
    check_bit("pc_set_o", pc_set_o, 1'b1);
    check_bit("instr_done_o", instr_done_o, 1'b0);
    if (is_jalr) begin
      check_ex(ALU_ADD, rf_rdata_a_i, sext(word_t'(imm_i), 12));
    end else begin
      check_ex(ALU_ADD, pc_i, sext(word_t'(imm_j), 21));
    end
    wait_done(1'b0, delay);
    // Link value
    check_ex(ALU_ADD, pc_i, word_t'(`ID_PC_INCR));
    check_complete(1'b1);
    release_instr();
  endtask

  task automatic run_illegal(input instr_t ins);
    start(ins, 1'b1);
    check_bit("illegal_insn_o", illegal_insn_o, 1'b1);
    check_bit("instr_done_o", instr_done_o, 1'b1);
    check_bit("rf_we_o", rf_we_o, 1'b0);
    check_bit("lsu_req_o", lsu_req_o, 1'b0);
    check_bit("pc_set_o", pc_set_o, 1'b0);
    release_instr();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  initial begin : main
    seed              = 36;
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_i           = '0;
    pc_i              = '0;
    rf_rdata_a_i      = '0;
    rf_rdata_b_i      = '0;
    branch_decision_i = 1'b0;
    ex_valid_i        = 1'b1;
    result_ex_i       = '0;
    lsu_resp_valid_i  = 1'b0;

    // Reset for five cycles, then idle
    repeat (5) begin
      @(negedge clk_i);
      check_quiet();
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_quiet();
    end

    for (int f = 0; f < 8; f++) begin
      alu_rr(3'(f), 1'b0, BASE_OP[f]);
      alu_ri(3'(f), 1'b0, BASE_OP[f]);
    end
    alu_rr(3'b000, 1'b1, ALU_SUB);
    alu_rr(3'b101, 1'b1, ALU_SRA);
    alu_ri(3'b101, 1'b1, ALU_SRA);
    run_upper(1'b1);
    run_upper(1'b0);

    // Loads lb lh lw lbu lhu, stores sb sh sw
    run_mem(1'b1, 3'b000, LSU_BYTE, 1'b1);
    run_mem(1'b1, 3'b001, LSU_HALF, 1'b1);
    run_mem(1'b1, 3'b010, LSU_WORD, 1'b1);
    run_mem(1'b1, 3'b100, LSU_BYTE, 1'b0);
    run_mem(1'b1, 3'b101, LSU_HALF, 1'b0);
    run_mem(1'b0, 3'b000, LSU_BYTE, 1'b0);
    run_mem(1'b0, 3'b001, LSU_HALF, 1'b0);
    run_mem(1'b0, 3'b010, LSU_WORD, 1'b0);

    for (int b = 0; b < 6; b++) begin
      run_branch(BR_F3[b], BR_OP[b], 1'b0);
      run_branch(BR_F3[b], BR_OP[b], 1'b1);
    end

    run_jump(1'b0, 0);
    run_jump(1'b1, 0);
    run_jump(1'b0, 3);
    run_jump(1'b1, 2);

    // Custom opcode, M-extension funct7, JALR with nonzero funct3
    run_illegal(32'h0000_050b);
    run_illegal(enc_r(7'h01, 5'd3, 5'd2, 3'b000, 5'd1, OPC_OP));
    run_illegal(enc_i(12'h010, 5'd4, 3'b001, 5'd1, OPC_JALR));

    repeat (2) @(posedge clk_i);
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/id_stage.sv ====
/*
 * RV32I decode and issue stage
 * Decoder, operand mux and sequencer for a core without writeback stage
 */

`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Fetch side
  input  logic      instr_valid_i,
  input  instr_t    instr_i,
  input  word_t     pc_i,
  output logic      instr_done_o,
  output logic      illegal_insn_o,

  // Register file read
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  input  word_t     rf_rdata_a_i,
  input  word_t     rf_rdata_b_i,

  // EX
  output ex_req_t   ex_req_o,
  input  logic      branch_decision_i,
  input  logic      ex_valid_i,
  input  word_t     result_ex_i,

  // LSU
  output logic      lsu_req_o,
  output lsu_req_t  lsu_req_s_o,
  input  logic      lsu_resp_valid_i,

  // Redirect to fetch
  output logic      pc_set_o,

  // Register file write
  output logic      rf_we_o,
  output reg_addr_t rf_waddr_o,
  output word_t     rf_wdata_o
);

  dec_ctrl_t ctrl;
  imm_set_t  imm;
  logic      first_cycle;

  // Combinational decode of the current instruction
  id_decoder decoder0 (
    .instr_i      (instr_i),
    .first_cycle_i(first_cycle),
    .ctrl_o       (ctrl),
    .imm_o        (imm),
    .rf_raddr_a_o (rf_raddr_a_o),
    .rf_raddr_b_o (rf_raddr_b_o),
    .rf_waddr_o   (rf_waddr_o)
  );

  id_operand_mux operand_mux0 (
    .ctrl_i      (ctrl),
    .imm_i       (imm),
    .pc_i        (pc_i),
    .rf_rdata_a_i(rf_rdata_a_i),
    .rf_rdata_b_i(rf_rdata_b_i),
    .ex_req_o    (ex_req_o),
    .lsu_req_s_o (lsu_req_s_o)
  );

  id_fsm fsm0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_valid_i    (instr_valid_i),
    .ctrl_i           (ctrl),
    .branch_decision_i(branch_decision_i),
    .ex_valid_i       (ex_valid_i),
    .lsu_resp_valid_i (lsu_resp_valid_i),
    .first_cycle_o    (first_cycle),
    .instr_done_o     (instr_done_o),
    .lsu_req_o        (lsu_req_o),
    .rf_we_o          (rf_we_o),
    .pc_set_o         (pc_set_o),
    .illegal_insn_o   (illegal_insn_o)
  );

  // Write data straight from EX
  assign rf_wdata_o = result_ex_i;

endmodule

`default_nettype wire

// ==== src/id_fsm.sv ====
/*
 * Decode stage sequencer
 * First/multi-cycle FSM, stalls, done pulse, request gating and PC redirect
 */

`timescale 1ns/1ps
`default_nettype none

module id_fsm import id_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      instr_valid_i,
  input  dec_ctrl_t ctrl_i,
  input  logic      branch_decision_i,
  input  logic      ex_valid_i,
  input  logic      lsu_resp_valid_i,
  output logic      first_cycle_o,
  output logic      instr_done_o,
  output logic      lsu_req_o,
  output logic      rf_we_o,
  output logic      pc_set_o,
  output logic      illegal_insn_o
);

  id_fsm_e id_fsm_q, id_fsm_d;

  logic stall_mem;
  logic stall_branch;
  logic stall_jump;
  logic stall_id;
  logic instr_done;
  logic multicycle_done;
  logic branch_set_d, branch_set_q;
  logic jump_set_raw;
  logic set_done_d, set_done_q;

  ////////////////////////////////////////////////////////////////////////////
  // State register
  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_reg
    if (!rst_ni) begin
      id_fsm_q <= FIRST_CYCLE;
    end else if (instr_valid_i) begin
      id_fsm_q <= id_fsm_d;
    end
  end

  // Instruction stays in its first cycle until it moves on
  assign first_cycle_o = instr_valid_i & (id_fsm_q == FIRST_CYCLE);

  // Loads and stores wait for the LSU, everything else for EX
  assign multicycle_done = ctrl_i.lsu_req ? lsu_resp_valid_i : ex_valid_i;

  always_comb begin : fsm_next
    id_fsm_d     = id_fsm_q;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    branch_set_d = 1'b0;
    jump_set_raw = 1'b0;

    if (instr_valid_i) begin
      unique case (id_fsm_q)
        FIRST_CYCLE: begin
          if (ctrl_i.lsu_req) begin
            id_fsm_d = MULTI_CYCLE;
          end else if (ctrl_i.branch) begin
            // Taken branch computes its target next cycle
            id_fsm_d     = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end else if (ctrl_i.jump) begin
            // Target ready now, link value next cycle
            id_fsm_d     = MULTI_CYCLE;
            stall_jump   = 1'b1;
            jump_set_raw = 1'b1;
          end
        end
        MULTI_CYCLE: begin
          if (multicycle_done) begin
            id_fsm_d = FIRST_CYCLE;
          end else begin
            stall_branch = ctrl_i.branch;
            stall_jump   = ctrl_i.jump;
          end
        end
        default: id_fsm_d = FIRST_CYCLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stalls and completion
  // Memory ops always stall cycle 1, then until the response
  assign stall_mem  = instr_valid_i & ctrl_i.lsu_req & (~lsu_resp_valid_i | first_cycle_o);
  assign stall_id   = stall_mem | stall_branch | stall_jump;
  assign instr_done = instr_valid_i & ~stall_id;

  assign instr_done_o   = instr_done;
  assign lsu_req_o      = ctrl_i.lsu_req & first_cycle_o;
  assign rf_we_o        = ctrl_i.rf_we & instr_done;
  assign illegal_insn_o = instr_valid_i & ctrl_i.illegal;

  ////////////////////////////////////////////////////////////////////////////
  // Redirect
  // Branch decision flopped, redirect in cycle 2
  // Set-done flag blocks a second redirect of the same instruction
  assign set_done_d = (branch_set_q | jump_set_raw | set_done_q) & ~instr_done;

  always_ff @(posedge clk_i or negedge rst_ni) begin : redirect_reg
    if (!rst_ni) begin
      branch_set_q <= 1'b0;
      set_done_q   <= 1'b0;
    end else begin
      branch_set_q <= branch_set_d;
      set_done_q   <= set_done_d;
    end
  end

  assign pc_set_o = (branch_set_q | jump_set_raw) & ~set_done_q;

endmodule

`default_nettype wire

// ==== src/id_operand_mux.sv ====
/*
 * ALU operand selection
 * Operand A, operand B and the store data for the current instruction
 */

`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module id_operand_mux import id_pkg::*; (
  input  dec_ctrl_t ctrl_i,
  input  imm_set_t  imm_i,
  input  word_t     pc_i,
  input  word_t     rf_rdata_a_i,
  input  word_t     rf_rdata_b_i,
  output ex_req_t   ex_req_o,
  output lsu_req_t  lsu_req_s_o
);

  word_t imm_b;

  ////////////////////////////////////////////////////////////////////////////
  // Immediate for operand B
  always_comb begin : imm_b_mux
    unique case (ctrl_i.imm_b_sel)
      IMM_B_I:       imm_b = imm_i.i_type;
      IMM_B_S:       imm_b = imm_i.s_type;
      IMM_B_B:       imm_b = imm_i.b_type;
      IMM_B_U:       imm_b = imm_i.u_type;
      IMM_B_J:       imm_b = imm_i.j_type;
      // Link value offset
      IMM_B_INCR_PC: imm_b = word_t'(`ID_PC_INCR);
      default:       imm_b = word_t'(`ID_PC_INCR);
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operand A
  always_comb begin : op_a_mux
    unique case (ctrl_i.op_a_sel)
      OP_A_REG_A:  ex_req_o.operand_a = rf_rdata_a_i;
      OP_A_CURRPC: ex_req_o.operand_a = pc_i;
      // LUI adds to zero
      default:     ex_req_o.operand_a = '0;
    endcase
  end

  // Operand B, register or immediate
  assign ex_req_o.operand_b = (ctrl_i.op_b_sel == OP_B_IMM) ? imm_b : rf_rdata_b_i;
  assign ex_req_o.alu_op    = ctrl_i.alu_op;

  // LSU side-band, store data always rs2
  assign lsu_req_s_o.we        = ctrl_i.lsu_we;
  assign lsu_req_s_o.data_type = ctrl_i.lsu_type;
  assign lsu_req_s_o.sign_ext  = ctrl_i.lsu_sign_ext;
  assign lsu_req_s_o.wdata     = rf_rdata_b_i;

endmodule

`default_nettype wire

// ==== src/id_decoder.sv ====
/*
 * RV32I instruction decoder
 * Opcode and function fields to ALU, operand and LSU controls,
 * register indices and the sign-extended immediates
 */

`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module id_decoder import id_pkg::*; (
  input  instr_t    instr_i,
  input  logic      first_cycle_i,
  output dec_ctrl_t ctrl_o,
  output imm_set_t  imm_o,
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  output reg_addr_t rf_waddr_o
);

  // Base opcodes
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_JAL    = 7'h6f;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       sign;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign sign   = instr_i[31];

  // Register fields sit at fixed positions
  assign rf_raddr_a_o = instr_i[19:15];
  assign rf_raddr_b_o = instr_i[24:20];
  assign rf_waddr_o   = instr_i[11:7];

  ////////////////////////////////////////////////////////////////////////////
  // Immediates
  assign imm_o.i_type = {{(`ID_XLEN-12){sign}}, instr_i[31:20]};
  assign imm_o.s_type = {{(`ID_XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
  // Branch offset, bit 0 always zero
  assign imm_o.b_type = {{(`ID_XLEN-13){sign}}, sign, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
  assign imm_o.u_type = {instr_i[31:12], {(`ID_XLEN-20){1'b0}}};
  assign imm_o.j_type = {{(`ID_XLEN-21){sign}}, sign, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // Control decode
  always_comb begin : decode
    ctrl_o.alu_op       = ALU_ADD;
    ctrl_o.op_a_sel     = OP_A_REG_A;
    ctrl_o.op_b_sel     = OP_B_REG_B;
    ctrl_o.imm_b_sel    = IMM_B_I;
    ctrl_o.rf_we        = 1'b0;
    ctrl_o.lsu_req      = 1'b0;
    ctrl_o.lsu_we       = 1'b0;
    ctrl_o.lsu_type     = LSU_WORD;
    ctrl_o.lsu_sign_ext = 1'b0;
    ctrl_o.branch       = 1'b0;
    ctrl_o.jump         = 1'b0;
    ctrl_o.illegal      = 1'b0;

    unique case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        ctrl_o.rf_we = 1'b1;
        if (opcode == OPC_OP_IMM) begin
          ctrl_o.op_b_sel = OP_B_IMM;
        end
        unique case (funct3)
          3'b000: ctrl_o.alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b001: ctrl_o.alu_op = ALU_SLL;
          3'b010: ctrl_o.alu_op = ALU_SLT;
          3'b011: ctrl_o.alu_op = ALU_SLTU;
          3'b100: ctrl_o.alu_op = ALU_XOR;
          3'b101: ctrl_o.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110: ctrl_o.alu_op = ALU_OR;
          default: ctrl_o.alu_op = ALU_AND;
        endcase
        // funct7 legal only as zero, or 0x20 for sub and arithmetic shift
        if (opcode == OPC_OP || funct3 == 3'b001 || funct3 == 3'b101) begin
          if (funct7 == 7'h20) begin
            ctrl_o.illegal = ~(funct3 == 3'b101 || (funct3 == 3'b000 && opcode == OPC_OP));
          end else begin
            ctrl_o.illegal = (funct7 != 7'h00);
          end
        end
      end

      OPC_LUI, OPC_AUIPC: begin
        // Zero or PC plus upper immediate
        ctrl_o.op_a_sel  = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_CURRPC;
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.imm_b_sel = IMM_B_U;
        ctrl_o.rf_we     = 1'b1;
      end

      OPC_LOAD, OPC_STORE: begin
        // Address is rs1 plus offset
        ctrl_o.op_b_sel     = OP_B_IMM;
        ctrl_o.imm_b_sel    = (opcode == OPC_STORE) ? IMM_B_S : IMM_B_I;
        ctrl_o.lsu_req      = 1'b1;
        ctrl_o.lsu_we       = (opcode == OPC_STORE);
        ctrl_o.rf_we        = (opcode == OPC_LOAD);
        ctrl_o.lsu_sign_ext = (opcode == OPC_LOAD) & ~funct3[2];
        unique case (funct3[1:0])
          2'b00:   ctrl_o.lsu_type = LSU_BYTE;
          2'b01:   ctrl_o.lsu_type = LSU_HALF;
          default: ctrl_o.lsu_type = LSU_WORD;
        endcase
        // Unsigned variants only for loads of byte and half
        ctrl_o.illegal = (funct3[1:0] == 2'b11) ||
                         (funct3[2] && (opcode == OPC_STORE || funct3[1]));
      end

      OPC_BRANCH: begin
        ctrl_o.branch = 1'b1;
        if (first_cycle_i) begin
          // Compare rs1 with rs2
          unique case (funct3)
            3'b000:  ctrl_o.alu_op = ALU_EQ;
            3'b001:  ctrl_o.alu_op = ALU_NE;
            3'b100:  ctrl_o.alu_op = ALU_LT;
            3'b101:  ctrl_o.alu_op = ALU_GE;
            3'b110:  ctrl_o.alu_op = ALU_LTU;
            default: ctrl_o.alu_op = ALU_GEU;
          endcase
        end else begin
          // Target PC + B offset
          ctrl_o.op_a_sel  = OP_A_CURRPC;
          ctrl_o.op_b_sel  = OP_B_IMM;
          ctrl_o.imm_b_sel = IMM_B_B;
        end
        ctrl_o.illegal = (funct3[2:1] == 2'b01);
      end

      OPC_JAL, OPC_JALR: begin
        ctrl_o.jump     = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_b_sel = OP_B_IMM;
        if (first_cycle_i) begin
          // Jump target
          ctrl_o.op_a_sel  = (opcode == OPC_JAL) ? OP_A_CURRPC : OP_A_REG_A;
          ctrl_o.imm_b_sel = (opcode == OPC_JAL) ? IMM_B_J : IMM_B_I;
        end else begin
          // Link value
          ctrl_o.op_a_sel  = OP_A_CURRPC;
          ctrl_o.imm_b_sel = IMM_B_INCR_PC;
        end
        ctrl_o.illegal = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end

      default: ctrl_o.illegal = 1'b1;
    endcase

    // Illegal encodings request nothing
    if (ctrl_o.illegal) begin
      ctrl_o.rf_we   = 1'b0;
      ctrl_o.lsu_req = 1'b0;
      ctrl_o.lsu_we  = 1'b0;
      ctrl_o.branch  = 1'b0;
      ctrl_o.jump    = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/id_pkg.sv ====
/*
 * Decode stage package
 * Width types, selector encodings and the structs passed between blocks
 */

`default_nettype none

`include "id_settings.svh"

package id_pkg;

  typedef logic [`ID_XLEN-1:0]       word_t;
  typedef logic [31:0]               instr_t;
  typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

  // Arithmetic, logic and compare operations
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;

  // Immediate source for operand B
  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC
  } imm_b_sel_e;

  // Access size, LSU encoding
  typedef enum logic [1:0] {LSU_WORD = 2'b00, LSU_HALF = 2'b01, LSU_BYTE = 2'b10} lsu_type_e;

  typedef enum logic {FIRST_CYCLE, MULTI_CYCLE} id_fsm_e;

  // Decoder control fields
  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_b_sel_e imm_b_sel;
    logic       rf_we;
    logic       lsu_req;
    logic       lsu_we;
    lsu_type_e  lsu_type;
    logic       lsu_sign_ext;
    logic       branch;
    logic       jump;
    logic       illegal;
  } dec_ctrl_t;

  // All five sign-extended immediates
  typedef struct packed {
    word_t i_type;
    word_t s_type;
    word_t b_type;
    word_t u_type;
    word_t j_type;
  } imm_set_t;

  // Request to EX
  typedef struct packed {
    alu_op_e alu_op;
    word_t   operand_a;
    word_t   operand_b;
  } ex_req_t;

  // Side-band fields of an LSU request
  typedef struct packed {
    logic      we;
    lsu_type_e data_type;
    logic      sign_ext;
    word_t     wdata;
  } lsu_req_t;

endpackage

`default_nettype wire

// ==== src/id_settings.svh ====
/*
 * Decode stage widths and constants
 * Data and PC width, register index width and link increment
 */

`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// Data path and PC width
`define ID_XLEN 32

// 32 architectural registers
`define ID_REG_ADDR_W 5

// Next sequential PC, no compressed support
`define ID_PC_INCR 4

`endif
